//--- compile.f
dp_msg_pkg.sv
dp_host_pkg.sv
dp_msg_src.sv
dp_msg_slv_egr.sv
dp_msg_sys_top.sv
dp_msg_sys_checker.sv
dp_msg_sys_tb.sv

//--- dp_host_pkg.sv
/*
    Host bus definitions
    Wishbone address and data types
    Wishbone request and response structs
    Register map and write word bit positions
*/

package dp_host_pkg;

    // Word address and data
    typedef logic [3:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // Sent message counter, wraps at 2^16
    typedef logic [15:0] msg_cnt_t;

    // Master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // Register addresses
    localparam wb_adr_t reg_msg_wr  = 4'd0;
    localparam wb_adr_t reg_msg_cnt = 4'd1;

    // Flags inside a message word write
    localparam int wr_som_bit = 16;
    localparam int wr_eom_bit = 17;

endpackage

//--- dp_msg_pkg.sv
/*
    Message ring definitions
    Ring word, egress index and node identifier types
    Ring beat and egress beat structs
    Header field positions
*/

package dp_msg_pkg;

    // Header word layout
    localparam int hdr_put_bit  = 15;
    localparam int hdr_id_lsb   = 8;
    localparam int hdr_id_width = 7;

    // Ring data word
    typedef logic [15:0] msg_word_t;

    // Running index of egressed words
    typedef logic [5:0] msg_idx_t;

    // Node identifier as carried in the header
    typedef logic [hdr_id_width-1:0] msg_id_t;

    // One ring beat
    typedef struct packed {
        logic      som;
        logic      eom;
        msg_word_t dat;
        logic      vld;
    } msg_t;

    // One egress beat
    typedef struct packed {
        msg_idx_t  idx;
        logic      first;
        logic      last;
        msg_word_t dat;
        logic      vld;
    } egr_t;

endpackage

//--- dp_msg_slv_egr.sv
/*
    Message ring slave egress stage
    Forwards the ring with one cycle delay
    Decodes put headers for this node and egresses the words that follow
*/

`timescale 1ns/1ps

module dp_msg_slv_egr
#(
    parameter dp_msg_pkg::msg_id_t node_id   = '0,
    parameter int unsigned         idx_width = $bits(dp_msg_pkg::msg_idx_t)
)
(
    input  logic               CLK_IN,
    input  logic               RST_IN,
    input  dp_msg_pkg::msg_t   msg_in,
    output dp_msg_pkg::msg_t   msg_out,
    output dp_msg_pkg::egr_t   egr
);

    import dp_msg_pkg::*;

    // Registered ring beat
    logic                 som_q;
    logic                 eom_q;
    logic                 vld_q;
    msg_word_t            dat_q;

    // Message for this node in progress
    logic                 act_q;
    logic [idx_width-1:0] idx_q;

    // Header decode on the registered beat
    logic                 hdr_hit;
    logic                 egr_vld;

    // Ring flags
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            som_q <= 1'b0;
            eom_q <= 1'b0;
            vld_q <= 1'b0;
        end
        else
        begin
            som_q <= msg_in.som;
            eom_q <= msg_in.eom;
            vld_q <= msg_in.vld;
        end
    end

    // Ring data
    always_ff @(posedge CLK_IN)
    begin
        dat_q <= msg_in.dat;
    end

    // Start of message, put bit set, our identifier
    assign hdr_hit = vld_q && som_q && dat_q[hdr_put_bit]
                     && (dat_q[hdr_id_lsb +: hdr_id_width] == node_id);

    // Active flag
    // Header beat itself sees act low, so it is never egressed
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            act_q <= 1'b0;
        end
        else if (vld_q && eom_q)
        begin
            // End of any message closes it
            act_q <= 1'b0;
        end
        else if (hdr_hit)
        begin
            act_q <= 1'b1;
        end
    end

    // Every valid beat while active is egressed
    assign egr_vld = act_q && vld_q;

    // Word index
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            idx_q <= '0;
        end
        else if (!act_q)
        begin
            // Idle, ready for next message
            idx_q <= '0;
        end
        else if (egr_vld)
        begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // Ring forward
    assign msg_out.som = som_q;
    assign msg_out.eom = eom_q;
    assign msg_out.dat = dat_q;
    assign msg_out.vld = vld_q;

    // Egress beat, aligned with the forwarded beat
    assign egr.idx   = msg_idx_t'(idx_q);
    assign egr.first = egr_vld && (idx_q == '0);
    assign egr.last  = egr_vld && eom_q;
    assign egr.dat   = dat_q;
    assign egr.vld   = egr_vld;

endmodule

//--- dp_msg_src.sv
/*
    Message ring source
    Wishbone classic slave with single-cycle ack
    Host writes become ring beats, eom beats are counted
*/

`timescale 1ns/1ps

module dp_msg_src
(
    input  logic                 CLK_IN,
    input  logic                 RST_IN,
    input  dp_host_pkg::wb_req_t wb_req,
    output dp_host_pkg::wb_rsp_t wb_rsp,
    output dp_msg_pkg::msg_t     msg
);

    import dp_host_pkg::*;
    import dp_msg_pkg::*;

    // New cycle seen, not yet acked
    logic      req_go;
    // Write to the message register
    logic      wr_msg;
    logic      ack_q;
    wb_dat_t   rd_dat_q;
    msg_cnt_t  cnt_q;

    // Ring beat registers
    logic      som_q;
    logic      eom_q;
    logic      vld_q;
    msg_word_t dat_q;

    // Ack drops the request for one cycle so a held cycle acks once
    assign req_go = wb_req.cyc && wb_req.stb && !ack_q;

    assign wr_msg = req_go && wb_req.we && (wb_req.adr == reg_msg_wr);

    // Ack pulse
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= req_go;
        end
    end

    // Read data, zero for anything but the counter
    always_ff @(posedge CLK_IN)
    begin
        if (req_go && !wb_req.we && (wb_req.adr == reg_msg_cnt))
        begin
            rd_dat_q <= wb_dat_t'(cnt_q);
        end
        else
        begin
            rd_dat_q <= '0;
        end
    end

    // Beat flags, one valid cycle per write
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            som_q <= 1'b0;
            eom_q <= 1'b0;
            vld_q <= 1'b0;
        end
        else
        begin
            vld_q <= wr_msg;
            som_q <= wr_msg && wb_req.dat[wr_som_bit];
            eom_q <= wr_msg && wb_req.dat[wr_eom_bit];
        end
    end

    // Beat payload from the low half of the write
    always_ff @(posedge CLK_IN)
    begin
        if (wr_msg)
        begin
            dat_q <= wb_req.dat[$bits(msg_word_t)-1:0];
        end
    end

    // Sent messages, updated together with the beat
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            cnt_q <= '0;
        end
        else if (wr_msg && wb_req.dat[wr_eom_bit])
        begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Host response
    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;

    // Ring output
    assign msg.som = som_q;
    assign msg.eom = eom_q;
    assign msg.dat = dat_q;
    assign msg.vld = vld_q;

endmodule

//--- dp_msg_sys_checker.sv
/*
    Egress stage checker bound into each slave egress stage
    Egress beat is the stage input delayed by one cycle
    First and last flag rules, no egress before a matching header
*/

`timescale 1ns/1ps

module dp_msg_sys_checker
#(
    parameter dp_msg_pkg::msg_id_t node_id = '0
)
(
    input logic             CLK_IN,
    input logic             RST_IN,
    input dp_msg_pkg::msg_t msg_in,
    input dp_msg_pkg::msg_t msg_out,
    input dp_msg_pkg::egr_t egr
);

    import dp_msg_pkg::*;

    // Matching put header on the forwarded ring
    logic     hdr_hit;
    // Matching put header seen since reset
    logic     hdr_seen_q;
    // Egressed beats since the last matching header
    msg_idx_t n_egr_q;

    // Sticky flag per property
    logic fail_match = 1'b0;
    logic fail_first = 1'b0;
    logic fail_last  = 1'b0;
    logic fail_hdr   = 1'b0;
    logic failed;

    assign failed = fail_match | fail_first | fail_last | fail_hdr;

    assign hdr_hit = msg_out.vld && msg_out.som && msg_out.dat[hdr_put_bit]
                     && (msg_out.dat[hdr_id_lsb +: hdr_id_width] == node_id);

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            hdr_seen_q <= 1'b0;
            n_egr_q    <= '0;
        end
        else if (hdr_hit)
        begin
            hdr_seen_q <= 1'b1;
            n_egr_q    <= '0;
        end
        else if (egr.vld)
        begin
            n_egr_q <= n_egr_q + 1'b1;
        end
    end

    // Egress word is the stage input of the previous cycle
    egr_matches_ring: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        egr.vld |-> (msg_out.vld && $past(msg_in.vld)
                     && (egr.dat == $past(msg_in.dat))))
    else
    begin
        fail_match = 1'b1;
        $error("egress beat differs from the ring beat one cycle earlier");
    end

    // First word carries index 0 and follows the header directly
    first_at_idx0: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        egr.first |-> ((egr.idx == '0) && (n_egr_q == '0)))
    else
    begin
        fail_first = 1'b1;
        $error("first flag not on the first egressed word");
    end

    // Last word only on the end of message
    last_on_eom: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        egr.last |-> $past(msg_in.vld && msg_in.eom))
    else
    begin
        fail_last = 1'b1;
        $error("last flag without eom on the ring");
    end

    // Nothing egressed before this node was addressed
    egr_after_hdr: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        egr.vld |-> hdr_seen_q)
    else
    begin
        fail_hdr = 1'b1;
        $error("egress beat before any matching header");
    end

endmodule

bind dp_msg_slv_egr dp_msg_sys_checker
#(
    .node_id (node_id)
)
chk_i
(
    .CLK_IN  (CLK_IN),
    .RST_IN  (RST_IN),
    .msg_in  (msg_in),
    .msg_out (msg_out),
    .egr     (egr)
);

//--- dp_msg_sys_tb.sv
/*
    Message ring subsystem testbench
    Clock, reset, Wishbone write and read tasks, LCG payloads
    Reference queues for the ring output and both egress ports
    Timeout and final report
*/

`timescale 1ns/1ps

module dp_msg_sys_tb;

    import dp_msg_pkg::*;
    import dp_host_pkg::*;

    localparam msg_id_t node_a = 7'd3;
    localparam msg_id_t node_b = 7'd5;
    // Matches neither stage
    localparam msg_id_t node_x = 7'd9;
    localparam int      n_msg  = 8;

    logic    CLK_IN = 1'b0;
    logic    RST_IN;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    msg_t    msg_out;
    egr_t    egr_a;
    egr_t    egr_b;

    // Expected beats and the cycle each is due
    egr_t    exp_a[$];
    egr_t    exp_b[$];
    msg_t    exp_ring[$];
    int      due_a[$];
    int      due_b[$];
    int      due_ring[$];
    // Next entry to compare, per port
    int      rd_a = 0;
    int      rd_b = 0;
    int      rd_ring = 0;

    int          cyc_cnt = 0;
    int          cyc_limit;
    logic [31:0] rng_state;
    logic        wr_started;
    int          eom_sent;

    dp_msg_sys_top
    #(
        .node_id_a (node_a),
        .node_id_b (node_b),
        .idx_width ($bits(msg_idx_t))
    )
    dut_i
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .msg_out (msg_out),
        .egr_a   (egr_a),
        .egr_b   (egr_b)
    );

    // 4 ns period
    always #2 CLK_IN = ~CLK_IN;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_error(input string what);
        $display("CHECK FAILED at %0t ns: %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string what);
        $display("Run aborted: %s", what);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    // Cycle counter and timeout
    always @(posedge CLK_IN)
    begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt > cyc_limit)
        begin
            abort_run("timeout, stimulus did not finish within the cycle limit");
        end
    end

    // Classic cycle, held until ack, dropped 1 ns after the next edge
    task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                            output wb_dat_t rd_dat, output int ack_cyc);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge CLK_IN);
        while (!wb_rsp.ack)
        begin
            @(negedge CLK_IN);
        end
        rd_dat  = wb_rsp.dat;
        ack_cyc = cyc_cnt;
        @(posedge CLK_IN);
        #1;
        wb_req = '0;
    endtask

    // One ring beat, recorded for msg_out two cycles after ack
    task automatic write_beat(input msg_word_t word, input logic som, input logic eom,
                              output int ack_cyc);
        wb_dat_t dat;
        wb_dat_t unused_rd;
        msg_t    beat;
        dat             = '0;
        dat[15:0]       = word;
        dat[wr_som_bit] = som;
        dat[wr_eom_bit] = eom;
        wr_started = 1'b1;
        wb_cycle(1'b1, reg_msg_wr, dat, unused_rd, ack_cyc);
        beat.som = som;
        beat.eom = eom;
        beat.dat = word;
        beat.vld = 1'b1;
        exp_ring.push_back(beat);
        due_ring.push_back(ack_cyc + 2);
        if (eom)
        begin
            eom_sent = eom_sent + 1;
        end
    endtask

    // Header and len data words, egress expected only on the addressed port
    task automatic send_msg(input logic put, input msg_id_t id, input int len);
        msg_word_t word;
        egr_t      beat;
        int        ack_cyc;
        rng_state = lcg_next(rng_state);
        word = {put, id, rng_state[23:16]};
        write_beat(word, 1'b1, 1'b0, ack_cyc);
        for (int i = 0; i < len; i++)
        begin
            rng_state = lcg_next(rng_state);
            word = rng_state[31:16];
            write_beat(word, 1'b0, i == len - 1, ack_cyc);
            beat.idx   = msg_idx_t'(i);
            beat.first = (i == 0);
            beat.last  = (i == len - 1);
            beat.dat   = word;
            beat.vld   = 1'b1;
            if (put && (id == node_a))
            begin
                exp_a.push_back(beat);
                due_a.push_back(ack_cyc + 1);
            end
            if (put && (id == node_b))
            begin
                exp_b.push_back(beat);
                due_b.push_back(ack_cyc + 2);
            end
        end
    endtask

    // Outputs sampled mid cycle
    always @(negedge CLK_IN)
    begin
        if (!wr_started)
        begin
            assert (!wb_rsp.ack && !msg_out.vld && !egr_a.vld && !egr_b.vld && !egr_a.first
                    && !egr_a.last && !egr_b.first && !egr_b.last)
            else report_error("output active before the first write");
        end
        assert (!dut_i.egr_a_i.chk_i.failed && !dut_i.egr_b_i.chk_i.failed)
        else abort_run("an assertion in an egress stage checker fired");
        if (egr_a.vld)
        begin
            assert (rd_a < exp_a.size()) else report_error("unexpected beat on egr_a");
            assert (egr_a == exp_a[rd_a] && cyc_cnt == due_a[rd_a])
            else report_error($sformatf("egr_a %h at cycle %0d, expected %h at %0d",
                                        egr_a, cyc_cnt, exp_a[rd_a], due_a[rd_a]));
            rd_a = rd_a + 1;
        end
        assert (rd_a >= due_a.size() || due_a[rd_a] > cyc_cnt)
        else report_error("expected beat missing on egr_a");
        if (egr_b.vld)
        begin
            assert (rd_b < exp_b.size()) else report_error("unexpected beat on egr_b");
            assert (egr_b == exp_b[rd_b] && cyc_cnt == due_b[rd_b])
            else report_error($sformatf("egr_b %h at cycle %0d, expected %h at %0d",
                                        egr_b, cyc_cnt, exp_b[rd_b], due_b[rd_b]));
            rd_b = rd_b + 1;
        end
        assert (rd_b >= due_b.size() || due_b[rd_b] > cyc_cnt)
        else report_error("expected beat missing on egr_b");
        if (msg_out.vld)
        begin
            assert (rd_ring < exp_ring.size()) else report_error("unexpected beat on msg_out");
            assert (msg_out == exp_ring[rd_ring] && cyc_cnt == due_ring[rd_ring])
            else report_error($sformatf("msg_out %h at cycle %0d, expected %h at %0d",
                                        msg_out, cyc_cnt, exp_ring[rd_ring],
                                        due_ring[rd_ring]));
            rd_ring = rd_ring + 1;
        end
        assert (rd_ring >= due_ring.size() || due_ring[rd_ring] > cyc_cnt)
        else report_error("expected beat missing on msg_out");
    end

    initial
    begin
        logic    put_l [n_msg];
        msg_id_t id_l [n_msg];
        int      len_l [n_msg];
        int      total_beats;
        int      ack_cyc;
        wb_dat_t rd_dat;
        RST_IN     = 1'b1;
        wb_req     = '0;
        wr_started = 1'b0;
        eom_sent   = 0;
        rng_state  = 32'd52100;
        // Put bit clear on 2 and 6, foreign identifier on 3
        put_l = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
        id_l  = '{node_a, node_b, node_a, node_x, node_b, node_a, node_b, node_a};
        // Unmapped write adds one beat to the bound
        total_beats = 1;
        for (int m = 0; m < n_msg; m++)
        begin
            rng_state   = lcg_next(rng_state);
            len_l[m]    = 1 + int'(rng_state[18:16]);
            total_beats = total_beats + len_l[m] + 1;
        end
        cyc_limit = total_beats * 4 + 200;
        repeat (16) @(posedge CLK_IN);
        #1;
        RST_IN = 1'b0;
        // Quiet period after reset
        repeat (4) @(posedge CLK_IN);
        #1;
        for (int m = 0; m < n_msg; m++)
        begin
            send_msg(put_l[m], id_l[m], len_l[m]);
            wb_cycle(1'b0, reg_msg_cnt, '0, rd_dat, ack_cyc);
            assert (rd_dat == wb_dat_t'(eom_sent & 32'hffff))
            else report_error($sformatf("count %0d, expected %0d", rd_dat, eom_sent));
            if (m == 0)
            begin
                // Acked and dropped, no beat and no count
                wb_cycle(1'b1, 4'd3, 32'h0003_ffff, rd_dat, ack_cyc);
            end
        end
        wb_cycle(1'b0, 4'd2, '0, rd_dat, ack_cyc);
        assert (rd_dat == '0) else report_error("unmapped read returned nonzero data");
        repeat (8) @(posedge CLK_IN);
        if (rd_a == exp_a.size() && rd_b == exp_b.size() && rd_ring == exp_ring.size())
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            abort_run("some expected beats never appeared");
        end
    end

endmodule

//--- dp_msg_sys_top.sv
/*
    Message ring subsystem top
    Wishbone host source followed by two egress stages
*/

`timescale 1ns/1ps

module dp_msg_sys_top
#(
    parameter dp_msg_pkg::msg_id_t node_id_a = 7'd3,
    parameter dp_msg_pkg::msg_id_t node_id_b = 7'd5,
    parameter int unsigned         idx_width = $bits(dp_msg_pkg::msg_idx_t)
)
(
    input  logic                 CLK_IN,
    input  logic                 RST_IN,
    input  dp_host_pkg::wb_req_t wb_req,
    output dp_host_pkg::wb_rsp_t wb_rsp,
    output dp_msg_pkg::msg_t     msg_out,
    output dp_msg_pkg::egr_t     egr_a,
    output dp_msg_pkg::egr_t     egr_b
);

    import dp_msg_pkg::*;

    // Source to stage a
    msg_t msg_src;
    // Stage a to stage b
    msg_t msg_a;

    // Host port and ring head
    dp_msg_src src_i
    (
        .CLK_IN (CLK_IN),
        .RST_IN (RST_IN),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .msg    (msg_src)
    );

    // First egress, one cycle after the source
    dp_msg_slv_egr
    #(
        .node_id   (node_id_a),
        .idx_width (idx_width)
    )
    egr_a_i
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .msg_in  (msg_src),
        .msg_out (msg_a),
        .egr     (egr_a)
    );

    // Second egress, ring tail
    dp_msg_slv_egr
    #(
        .node_id   (node_id_b),
        .idx_width (idx_width)
    )
    egr_b_i
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .msg_in  (msg_a),
        .msg_out (msg_out),
        .egr     (egr_b)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the message ring testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! command -v verilator >/dev/null 2>&1
then
    echo "verilator not found"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dp_msg_sys_tb --Mdir "$build_dir" -f compile.f
status=$?
if [ $status -ne 0 ]
then
    echo "build failed with status $status"
    exit 1
fi

# Keep running past a checker error so the testbench reports it
"./$build_dir/Vdp_msg_sys_tb" +verilator+error+limit+100 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]
then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F "** PASS **" "$log_file"
then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1
